// File: rtl/cam_pkg.sv
package cam_pkg;

    // ====================
    // lookup path widths
    // ====================
    localparam int key_w      = 64;
    localparam int num_slices = 4;
    localparam int slice_w    = key_w / num_slices;
    localparam int cam_depth  = 16;
    localparam int addr_w     = 4;
    localparam int payload_w  = 32;

    // reported when no entry matches
    localparam logic [addr_w-1:0] miss_addr = '1;

    // ====================
    // control stream
    // ====================
    localparam int ctrl_w = 64;

    localparam logic [15:0] ctrl_flag_value = 16'hf2f1;

    // header field positions
    localparam int flag_lsb      = 0;
    localparam int flag_w        = 16;
    localparam int lookup_id_lsb = 16;
    localparam int lookup_id_w   = 3;
    localparam int stage_id_lsb  = 19;
    localparam int stage_id_w    = 5;
    localparam int kind_lsb      = 24;
    localparam int kind_w        = 4;
    localparam int start_lsb     = 28;
    localparam int start_w       = 8;

    localparam logic [lookup_id_w-1:0] lookup_id_value  = 3'd2;
    localparam logic [stage_id_w-1:0]  default_stage_id = 5'd0;

    // table kind carried in the header
    typedef enum logic [kind_w-1:0] {
        kind_cam    = 4'd0,
        kind_action = 4'd2
    } entry_kind_t;

    typedef enum logic [1:0] {
        ctrl_idle,
        ctrl_entry,
        ctrl_pass
    } ctrl_state_t;

endpackage

// File: rtl/key_dispatch.sv
`timescale 1ns/1ps

module key_dispatch (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          key_valid,
    input  logic [cam_pkg::key_w-1:0]     key,
    input  logic [cam_pkg::payload_w-1:0] payload,
    output logic                          disp_valid,
    output logic [cam_pkg::key_w-1:0]     disp_key,
    output logic [cam_pkg::payload_w-1:0] disp_payload
);
    import cam_pkg::*;

    // strobe follows the input every cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            disp_valid <= 1'b0;
        end else begin
            disp_valid <= key_valid;
        end
    end

    // key and payload held until the next strobe
    always_ff @(posedge clk) begin
        if (key_valid) begin
            disp_key     <= key;
            disp_payload <= payload;
        end
    end

endmodule

// File: rtl/cam_slice.sv
`timescale 1ns/1ps

module cam_slice (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        cmp_valid,
    input  logic [cam_pkg::slice_w-1:0] cmp_data,
    input  logic                        wr_en,
    input  logic [cam_pkg::addr_w-1:0]  wr_addr,
    input  logic [cam_pkg::slice_w-1:0] wr_data,
    output logic                        match_valid,
    output logic [cam_pkg::cam_depth-1:0] match_vec
);
    import cam_pkg::*;

    logic [slice_w-1:0]   mem [cam_depth];
    logic [cam_depth-1:0] entry_valid;
    logic [cam_depth-1:0] match_now;

    // ====================
    // entry storage
    // ====================
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            entry_valid <= '0;
        end else if (wr_en) begin
            entry_valid[wr_addr] <= 1'b1;
        end
    end

    // ====================
    // compare
    // ====================
    // an entry being written this cycle is compared against its new value
    always_comb begin
        for (int i = 0; i < cam_depth; i++) begin
            if (wr_en && (wr_addr == addr_w'(i))) begin
                match_now[i] = (wr_data == cmp_data);
            end else begin
                match_now[i] = entry_valid[i] && (mem[i] == cmp_data);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            match_valid <= 1'b0;
        end else begin
            match_valid <= cmp_valid;
        end
    end

    always_ff @(posedge clk) begin
        match_vec <= match_now;
    end

endmodule

// File: rtl/match_resolve.sv
`timescale 1ns/1ps

module match_resolve (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          vec_valid,
    input  logic [cam_pkg::num_slices-1:0][cam_pkg::cam_depth-1:0] match_vecs,
    input  logic [cam_pkg::payload_w-1:0] disp_payload,
    output logic                          result_valid,
    output logic                          hit,
    output logic [cam_pkg::addr_w-1:0]    match_addr,
    output logic [cam_pkg::payload_w-1:0] payload_out
);
    import cam_pkg::*;

    logic [cam_depth-1:0] all_match;
    logic [addr_w-1:0]    first_addr;
    logic [payload_w-1:0] payload_d;

    // same entry must match in every slice
    always_comb begin
        all_match = '1;
        for (int s = 0; s < num_slices; s++) begin
            all_match = all_match & match_vecs[s];
        end
    end

    // lowest index wins
    always_comb begin
        first_addr = miss_addr;
        for (int i = cam_depth - 1; i >= 0; i--) begin
            if (all_match[i]) begin
                first_addr = addr_w'(i);
            end
        end
    end

    // payload waits one cycle while the slices compare
    always_ff @(posedge clk) begin
        payload_d <= disp_payload;
    end

    // ====================
    // result register
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result_valid <= 1'b0;
            hit          <= 1'b0;
        end else begin
            result_valid <= vec_valid;
            hit          <= vec_valid && (|all_match);
        end
    end

    always_ff @(posedge clk) begin
        match_addr  <= first_addr;
        payload_out <= payload_d;
    end

endmodule

// File: rtl/table_writer.sv
`timescale 1ns/1ps

module table_writer #(
    parameter logic [cam_pkg::stage_id_w-1:0] stage_id = cam_pkg::default_stage_id
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       ctrl_in_valid,
    input  logic [cam_pkg::ctrl_w-1:0] ctrl_in_data,
    input  logic                       ctrl_in_last,
    output logic                       ctrl_out_valid,
    output logic [cam_pkg::ctrl_w-1:0] ctrl_out_data,
    output logic                       ctrl_out_last,
    output logic                       wr_en,
    output logic [cam_pkg::addr_w-1:0] wr_addr,
    output logic [cam_pkg::key_w-1:0]  wr_key
);
    import cam_pkg::*;

    logic              in_valid_r;
    logic [ctrl_w-1:0] in_data_r;
    logic              in_last_r;

    ctrl_state_t       state;
    logic [addr_w-1:0] entry_idx;

    logic [flag_w-1:0]      hdr_flag;
    logic [stage_id_w-1:0]  hdr_stage;
    logic [lookup_id_w-1:0] hdr_lookup;
    entry_kind_t            hdr_kind;
    logic [start_w-1:0]     hdr_start;
    logic                   is_header;
    logic                   do_write;
    logic                   do_fwd;

    // ====================
    // input register
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_valid_r <= 1'b0;
            in_last_r  <= 1'b0;
        end else begin
            in_valid_r <= ctrl_in_valid;
            in_last_r  <= ctrl_in_last;
        end
    end

    always_ff @(posedge clk) begin
        in_data_r <= ctrl_in_data;
    end

    // header fields of the registered word
    assign hdr_flag   = in_data_r[flag_lsb +: flag_w];
    assign hdr_stage  = in_data_r[stage_id_lsb +: stage_id_w];
    assign hdr_lookup = in_data_r[lookup_id_lsb +: lookup_id_w];
    assign hdr_kind   = entry_kind_t'(in_data_r[kind_lsb +: kind_w]);
    assign hdr_start  = in_data_r[start_lsb +: start_w];

    assign is_header = (hdr_flag == ctrl_flag_value) && (hdr_stage == stage_id) &&
                       (hdr_lookup == lookup_id_value) && (hdr_kind == kind_cam);

    assign do_write = in_valid_r && (state == ctrl_entry);
    assign do_fwd   = in_valid_r && ((state == ctrl_pass) ||
                                     (state == ctrl_idle && !is_header));

    // ====================
    // packet FSM
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state          <= ctrl_idle;
            entry_idx      <= '0;
            wr_en          <= 1'b0;
            ctrl_out_valid <= 1'b0;
            ctrl_out_last  <= 1'b0;
        end else begin
            wr_en          <= do_write;
            ctrl_out_valid <= do_fwd;
            ctrl_out_last  <= do_fwd && in_last_r;

            case (state)
                ctrl_idle: begin
                    // header alone with last set loads nothing
                    if (in_valid_r && !in_last_r) begin
                        if (is_header) begin
                            state     <= ctrl_entry;
                            entry_idx <= hdr_start[addr_w-1:0];
                        end else begin
                            state <= ctrl_pass;
                        end
                    end
                end
                ctrl_entry: begin
                    if (in_valid_r) begin
                        entry_idx <= entry_idx + 1'b1;
                        if (in_last_r) begin
                            state <= ctrl_idle;
                        end
                    end
                end
                ctrl_pass: begin
                    if (in_valid_r && in_last_r) begin
                        state <= ctrl_idle;
                    end
                end
                default: begin
                    state <= ctrl_idle;
                end
            endcase
        end
    end

    // write data and forwarded word
    always_ff @(posedge clk) begin
        if (do_write) begin
            wr_addr <= entry_idx;
            wr_key  <= in_data_r[key_w-1:0];
        end
        if (do_fwd) begin
            ctrl_out_data <= in_data_r;
        end
    end

endmodule

// File: rtl/lookup_stage_top.sv
`timescale 1ns/1ps

module lookup_stage_top #(
    parameter logic [cam_pkg::stage_id_w-1:0] stage_id = cam_pkg::default_stage_id
) (
    input  logic                          clk,
    input  logic                          rst_n,
    // lookup path
    input  logic                          key_valid,
    input  logic [cam_pkg::key_w-1:0]     key,
    input  logic [cam_pkg::payload_w-1:0] payload,
    output logic                          result_valid,
    output logic                          hit,
    output logic [cam_pkg::addr_w-1:0]    match_addr,
    output logic [cam_pkg::payload_w-1:0] payload_out,
    // control path
    input  logic                          ctrl_in_valid,
    input  logic [cam_pkg::ctrl_w-1:0]    ctrl_in_data,
    input  logic                          ctrl_in_last,
    output logic                          ctrl_out_valid,
    output logic [cam_pkg::ctrl_w-1:0]    ctrl_out_data,
    output logic                          ctrl_out_last
);
    import cam_pkg::*;

    logic                 disp_valid;
    logic [key_w-1:0]     disp_key;
    logic [payload_w-1:0] disp_payload;

    logic                 wr_en;
    logic [addr_w-1:0]    wr_addr;
    logic [key_w-1:0]     wr_key;

    logic [num_slices-1:0]                slice_valid;
    logic [num_slices-1:0][cam_depth-1:0] match_vecs;

    key_dispatch u_dispatch (
        .clk          (clk),
        .rst_n        (rst_n),
        .key_valid    (key_valid),
        .key          (key),
        .payload      (payload),
        .disp_valid   (disp_valid),
        .disp_key     (disp_key),
        .disp_payload (disp_payload)
    );

    table_writer #(
        .stage_id (stage_id)
    ) u_writer (
        .clk            (clk),
        .rst_n          (rst_n),
        .ctrl_in_valid  (ctrl_in_valid),
        .ctrl_in_data   (ctrl_in_data),
        .ctrl_in_last   (ctrl_in_last),
        .ctrl_out_valid (ctrl_out_valid),
        .ctrl_out_data  (ctrl_out_data),
        .ctrl_out_last  (ctrl_out_last),
        .wr_en          (wr_en),
        .wr_addr        (wr_addr),
        .wr_key         (wr_key)
    );

    // slice g holds key bits g*slice_w upward
    for (genvar g = 0; g < num_slices; g++) begin : g_slice
        cam_slice u_slice (
            .clk         (clk),
            .rst_n       (rst_n),
            .cmp_valid   (disp_valid),
            .cmp_data    (disp_key[g*slice_w +: slice_w]),
            .wr_en       (wr_en),
            .wr_addr     (wr_addr),
            .wr_data     (wr_key[g*slice_w +: slice_w]),
            .match_valid (slice_valid[g]),
            .match_vec   (match_vecs[g])
        );
    end

    match_resolve u_resolve (
        .clk          (clk),
        .rst_n        (rst_n),
        .vec_valid    (&slice_valid),
        .match_vecs   (match_vecs),
        .disp_payload (disp_payload),
        .result_valid (result_valid),
        .hit          (hit),
        .match_addr   (match_addr),
        .payload_out  (payload_out)
    );

endmodule

// File: test/lookup_stage_chk.sv
`timescale 1ns/1ps

module lookup_stage_chk (
    input logic                       clk,
    input logic                       rst_n,
    input logic                       key_valid,
    input logic                       ctrl_in_valid,
    input logic                       result_valid,
    input logic                       hit,
    input logic [cam_pkg::addr_w-1:0] match_addr,
    input logic                       ctrl_out_valid
);
    import cam_pkg::*;

    int fail_count = 0;

    // ====================
    // pipeline latency
    // ====================
    result_after_key: assert property (
        @(posedge clk) disable iff (!rst_n) result_valid |-> $past(key_valid, 3)
    ) else begin
        $error("result_valid without key_valid three cycles earlier");
        fail_count++;
    end

    fwd_after_ctrl: assert property (
        @(posedge clk) disable iff (!rst_n) ctrl_out_valid |-> $past(ctrl_in_valid, 2)
    ) else begin
        $error("ctrl_out_valid without ctrl_in_valid two cycles earlier");
        fail_count++;
    end

    // a miss always reports the all ones address
    miss_address: assert property (
        @(posedge clk) disable iff (!rst_n) (result_valid && !hit) |-> (match_addr == miss_addr)
    ) else begin
        $error("miss reported with address %0d", match_addr);
        fail_count++;
    end

endmodule

bind lookup_stage_top lookup_stage_chk u_chk (
    .clk            (clk),
    .rst_n          (rst_n),
    .key_valid      (key_valid),
    .ctrl_in_valid  (ctrl_in_valid),
    .result_valid   (result_valid),
    .hit            (hit),
    .match_addr     (match_addr),
    .ctrl_out_valid (ctrl_out_valid)
);

// File: test/lookup_stage_tb.sv
`timescale 1ns/1ps

module lookup_stage_tb;
    import cam_pkg::*;

    // ====================
    // run length
    // ====================
    localparam logic [stage_id_w-1:0] dut_stage = 5'd5;
    localparam int mixed_rounds = 4;
    // reset plus every run_cycles call below
    localparam int total_cycles  = 2 + 40 + 30 + 40 + 12 + 20 + 20 + 50 + mixed_rounds * 30 + 6;
    localparam int timeout_limit = total_cycles + 100;

    typedef struct packed {
        int                   due;
        logic                 hit;
        logic [addr_w-1:0]    addr;
        logic [payload_w-1:0] payload;
    } lookup_exp_t;

    typedef struct packed {
        int                due;
        logic              last;
        logic [ctrl_w-1:0] data;
    } ctrl_exp_t;

    logic                 clk = 1'b0;
    logic                 rst_n;
    logic                 key_valid;
    logic [key_w-1:0]     key;
    logic [payload_w-1:0] payload;
    logic                 result_valid;
    logic                 hit;
    logic [addr_w-1:0]    match_addr;
    logic [payload_w-1:0] payload_out;
    logic                 ctrl_in_valid;
    logic [ctrl_w-1:0]    ctrl_in_data;
    logic                 ctrl_in_last;
    logic                 ctrl_out_valid;
    logic [ctrl_w-1:0]    ctrl_out_data;
    logic                 ctrl_out_last;

    integer seed = 32'ha941c641;
    int     cycle_count = 0;

    // reference model of the table and the packet parser
    logic [key_w-1:0]     model_key [cam_depth];
    logic [cam_depth-1:0] model_valid;
    logic                 pkt_open;
    logic                 pkt_load;
    logic [addr_w-1:0]    load_idx;
    logic [key_w-1:0]     dup_key;
    logic [ctrl_w:0]      ctrl_todo [$];
    lookup_exp_t          lookup_q [$];
    ctrl_exp_t            fwd_q [$];

    lookup_stage_top #(
        .stage_id (dut_stage)
    ) dut0 (
        .*
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_limit) begin
            $display("timeout: run still going after %0d cycles", cycle_count);
            $display("Simulation finished: FAIL");
            $fatal(1, "stopped by the cycle limit");
        end
    end

    task automatic report_error(input string msg);
        $display("error at %0d ns: %s", $time, msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic [key_w-1:0] rand_word();
        return {$random(seed), $random(seed)};
    endfunction

    // fields from bit 35 down to bit 0, upper bits are noise
    function automatic logic [ctrl_w-1:0] header_word(input logic [15:0] flag,
            input logic [4:0] stage, input logic [2:0] lookup, input logic [3:0] kind,
            input logic [7:0] start);
        logic [ctrl_w-1:0] w;
        w = rand_word();
        w[35:0] = {start, kind, stage, lookup, flag};
        return w;
    endfunction

    // lowest valid entry holding the key, else a miss at 15
    function automatic lookup_exp_t expect_lookup(input logic [key_w-1:0] k,
            input logic [payload_w-1:0] p);
        lookup_exp_t e;
        e.due     = cycle_count + 3;
        e.hit     = 1'b0;
        e.addr    = 4'd15;
        e.payload = p;
        for (int i = 0; i < cam_depth; i++) begin
            if (!e.hit && model_valid[i] && model_key[i] == k) begin
                e.hit  = 1'b1;
                e.addr = addr_w'(i);
            end
        end
        return e;
    endfunction

    task automatic apply_ctrl_word(input logic last, input logic [ctrl_w-1:0] d);
        ctrl_exp_t f;
        logic      is_hdr;
        is_hdr = (d[15:0] == ctrl_flag_value) && (d[23:19] == dut_stage) &&
                 (d[18:16] == lookup_id_value) && (d[27:24] == kind_cam);
        if (pkt_open && pkt_load) begin
            model_key[load_idx]   = d;
            model_valid[load_idx] = 1'b1;
            load_idx = load_idx + 1'b1;
        end else if (!pkt_open && is_hdr) begin
            pkt_load = 1'b1;
            load_idx = d[31:28];
        end else begin
            pkt_load = 1'b0;
            f.due  = cycle_count + 2;
            f.last = last;
            f.data = d;
            fwd_q.push_back(f);
        end
        pkt_open = !last;
    endtask

    // 1 random, 2 stored, 3 stored with one slice changed, 4 duplicate, 5 any of them
    function automatic logic [key_w-1:0] pick_key(input int mode);
        int               m;
        int               base;
        int               idx;
        logic [key_w-1:0] k;
        logic [15:0]      flip;
        m    = (mode == 5) ? 1 + rand_below(4) : mode;
        base = rand_below(cam_depth);
        idx  = -1;
        k    = rand_word();
        flip = 16'($random(seed)) | 16'h1;
        for (int i = cam_depth - 1; i >= 0; i--) begin
            if (model_valid[(base + i) % cam_depth]) begin
                idx = (base + i) % cam_depth;
            end
        end
        if (m == 4) begin
            k = dup_key;
        end else if (m >= 2 && idx >= 0) begin
            k = model_key[idx];
            if (m == 3) begin
                k = k ^ (key_w'(flip) << (slice_w * rand_below(num_slices)));
            end
        end
        return k;
    endfunction

    task automatic check_outputs();
        lookup_exp_t e;
        ctrl_exp_t   f;
        if (lookup_q.size() > 0 && lookup_q[0].due == cycle_count) begin
            e = lookup_q.pop_front();
            assert (result_valid) else report_error("no result returned for a lookup key");
            assert (hit == e.hit && match_addr == e.addr && payload_out == e.payload)
                else report_error($sformatf("hit %0b addr %0d payload %h, expected %0b %0d %h",
                    hit, match_addr, payload_out, e.hit, e.addr, e.payload));
        end else begin
            assert (!result_valid) else report_error("result_valid with no lookup pending");
        end
        if (fwd_q.size() > 0 && fwd_q[0].due == cycle_count) begin
            f = fwd_q.pop_front();
            assert (ctrl_out_valid && ctrl_out_last == f.last && ctrl_out_data == f.data)
                else report_error($sformatf("ctrl out valid %0b last %0b data %h, expected %0b %h",
                    ctrl_out_valid, ctrl_out_last, ctrl_out_data, f.last, f.data));
        end else begin
            assert (!ctrl_out_valid) else report_error("control word forwarded unexpectedly");
        end
    endtask

    task automatic run_cycles(input int n, input int mode, input int valid_pct);
        logic [ctrl_w:0] w;
        for (int c = 0; c < n; c++) begin
            key_valid = (mode != 0) && (rand_below(100) < valid_pct);
            key       = pick_key(mode);
            payload   = $random(seed);
            // lookups in this cycle miss a write issued in the same cycle
            if (key_valid) begin
                lookup_q.push_back(expect_lookup(key, payload));
            end
            ctrl_in_valid = ctrl_todo.size() > 0;
            ctrl_in_last  = 1'b0;
            ctrl_in_data  = rand_word();
            if (ctrl_in_valid) begin
                w = ctrl_todo.pop_front();
                ctrl_in_last = w[ctrl_w];
                ctrl_in_data = w[ctrl_w-1:0];
                apply_ctrl_word(ctrl_in_last, ctrl_in_data);
            end
            @(posedge clk);
            #2;
            check_outputs();
        end
    endtask

    task automatic queue_load(input int start, input int n, input bit dup);
        ctrl_todo.push_back({(n == 0), header_word(ctrl_flag_value, dut_stage,
            lookup_id_value, kind_cam, 8'(start))});
        for (int i = 0; i < n; i++) begin
            ctrl_todo.push_back({(i == n - 1), dup ? dup_key : rand_word()});
        end
    endtask

    // 0 stage, 1 lookup id, 2 flag, 3 action kind
    task automatic queue_foreign(input int sort, input int n);
        logic [15:0] flag;
        logic [4:0]  stage;
        logic [2:0]  lookup;
        logic [3:0]  kind;
        flag   = ctrl_flag_value;
        stage  = dut_stage;
        lookup = lookup_id_value;
        kind   = kind_cam;
        case (sort)
            0: stage = stage ^ 5'(1 + rand_below(31));
            1: lookup = lookup ^ 3'(1 + rand_below(7));
            2: flag = flag ^ 16'(1 + rand_below(65535));
            default: kind = kind_action;
        endcase
        ctrl_todo.push_back({(n == 1), header_word(flag, stage, lookup, kind,
            8'(rand_below(16)))});
        for (int i = 1; i < n; i++) begin
            ctrl_todo.push_back({(i == n - 1), rand_word()});
        end
    endtask

    initial begin
        rst_n         = 1'b0;
        key_valid     = 1'b0;
        key           = '0;
        payload       = '0;
        ctrl_in_valid = 1'b0;
        ctrl_in_data  = '0;
        ctrl_in_last  = 1'b0;
        model_valid   = '0;
        pkt_open      = 1'b0;
        pkt_load      = 1'b0;
        load_idx      = '0;
        dup_key       = '0;
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;

        // empty table
        run_cycles(40, 1, 75);

        // ====================
        // loads, then stored keys
        // ====================
        for (int p = 0; p < 4; p++) begin
            queue_load(rand_below(16), 1 + rand_below(5), 1'b0);
        end
        run_cycles(30, 0, 0);
        run_cycles(40, 2, 80);

        // same key at 12 and 3
        dup_key = rand_word();
        queue_load(12, 1, 1'b1);
        queue_load(3, 1, 1'b1);
        run_cycles(12, 0, 0);
        run_cycles(20, 3, 90);
        run_cycles(20, 4, 90);

        // ====================
        // foreign traffic
        // ====================
        for (int p = 0; p < 8; p++) begin
            queue_foreign(p % 4, 1 + rand_below(4));
        end
        queue_load(rand_below(16), 0, 1'b0);
        run_cycles(50, 5, 70);

        // back to back lookups
        for (int r = 0; r < mixed_rounds; r++) begin
            queue_load(rand_below(16), 1 + rand_below(4), 1'b0);
            queue_foreign(rand_below(4), 1 + rand_below(4));
            run_cycles(30, 5, 100);
        end
        run_cycles(6, 0, 0);

        assert (lookup_q.size() == 0 && fwd_q.size() == 0 && ctrl_todo.size() == 0)
            else report_error("expected results still outstanding at the end of the run");
        if (dut0.u_chk.fail_count == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            $display("bound checker reported %0d assertion failures", dut0.u_chk.fail_count);
            $display("Simulation finished: FAIL");
            $fatal(1, "checker assertions failed");
        end
    end

endmodule

// File: sim.f
rtl/cam_pkg.sv
rtl/key_dispatch.sv
rtl/cam_slice.sv
rtl/match_resolve.sv
rtl/table_writer.sv
rtl/lookup_stage_top.sv
test/lookup_stage_chk.sv
test/lookup_stage_tb.sv
